// ==== verilog.f ====
source/mem_pkg.sv
source/spi_pkg.sv
source/mem_tm_if.sv
source/data_mem.sv
source/mem_send_ctrl.sv
source/spi_master_w.sv
source/mem_dump_top.sv
tests/mem_dump_chk.sv
tests/tb_mem_dump.sv

// ==== tests/tb_mem_dump.sv ====
module tb_mem_dump;

    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;
    import spi_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 10;
    localparam int BAD_TRIES = 4;
    localparam int HOLD_CYCLES = 5;
    // Fill, bad accesses, readbacks, one locked write, refill
    localparam int APB_XFERS = 2 * MEM_DEPTH + 2 * BAD_TRIES + MEM_DEPTH + 1 + 2 * MEM_DEPTH;
    localparam int WORD_CYCLES = 2 + 2 * SPI_SCK_HALF * SPI_WORD_BITS + 4;
    localparam int DUMP_CYCLES = MEM_DEPTH * WORD_CYCLES + HOLD_CYCLES + 2;
    localparam int WD_CYCLES = 2 * (RST_CYCLES + 2 * APB_XFERS + 2 * DUMP_CYCLES);

    logic      clk;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    mem_addr_t paddr;
    mem_word_t pwdata;
    mem_word_t prdata;
    logic      pready;
    logic      pslverr;
    logic      dump_go;
    logic      dump_done;
    logic      sck;
    logic      ss;
    logic      mosi;

    logic [31:0] lfsr = 32'd72;
    mem_word_t   model [MEM_DEPTH];
    mem_word_t   rx_q [$];
    logic [31:0] rx_shift;
    int          rx_bits = 0;

    mem_dump_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .dump_go   (dump_go),
        .dump_done (dump_done),
        .sck       (sck),
        .ss        (ss),
        .mosi      (mosi)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected pslverr %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Starts and ends 1 ns after a rising edge, two cycles long
    task automatic apb_xfer(input logic wr, input mem_addr_t a, input mem_word_t d,
                            output mem_word_t rd, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        pwdata = d;
        tick(1);
        penable = 1'b1;
        @(negedge clk);
        rd = prdata;
        err = pslverr;
        check_flag("apb pready", 1'b1, pready);
        tick(1);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_word(input string name, input int idx, input mem_word_t d);
        mem_word_t rd;
        logic      err;
        apb_xfer(1'b1, mem_addr_t'(idx * MEM_ADDR_STEP), d, rd, err);
        check_resp(name, APB_OK, err);
        model[idx] = d;
    endtask

    task automatic read_image(input string name);
        mem_word_t rd;
        logic      err;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            apb_xfer(1'b0, mem_addr_t'(i * MEM_ADDR_STEP), '0, rd, err);
            check_resp(name, APB_OK, err);
            check_word($sformatf("%s word %0d", name, i), model[i], rd);
        end
    endtask

    task automatic run_dump(input string name, input logic try_write);
        logic [31:0] a;
        mem_word_t   d;
        mem_word_t   rd;
        logic        err;
        rx_q.delete();
        dump_go = 1'b1;
        if (try_write) begin
            tick(4);
            take_bits(4, a);
            take_bits(32, d);
            apb_xfer(1'b1, a * MEM_ADDR_STEP, d, rd, err);
            check_resp({name, " locked write"}, APB_ERR, err);
        end
        while (dump_done !== 1'b1) begin
            tick(1);
        end
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            tick(1);
            check_flag({name, " done held"}, 1'b1, dump_done);
            check_flag({name, " ss idle"}, 1'b1, ss);
        end
        if (rx_q.size() != MEM_DEPTH) begin
            abort_run($sformatf("mismatch %s word count: expected %0d, actual %0d",
                                name, MEM_DEPTH, rx_q.size()));
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            check_word($sformatf("%s word %0d", name, i), model[i], rx_q[i]);
        end
        dump_go = 1'b0;
        tick(1);
        check_flag({name, " done cleared"}, 1'b0, dump_done);
    endtask

    // SPI receiver, mode 0, MSB first
    always @(posedge sck) begin
        if (ss === 1'b0) begin
            rx_shift <= {rx_shift[30:0], mosi};
            rx_bits <= rx_bits + 1;
        end
    end

    always @(posedge ss) begin
        if (rx_bits == SPI_WORD_BITS) begin
            rx_q.push_back(rx_shift);
        end else if (rx_bits != 0) begin
            abort_run($sformatf("SPI frame closed after %0d bits", rx_bits));
        end
        rx_bits <= 0;
    end

    always @(i_dut.i_chk.fail_cnt) begin
        if (i_dut.i_chk.fail_cnt != 0) begin
            abort_run("a protocol assertion in the bound checker failed");
        end
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout, run did not end within %0d cycles", WD_CYCLES));
    end

    initial begin
        logic [31:0] a;
        logic [31:0] idx;
        logic [31:0] off;
        mem_word_t   d;
        mem_word_t   rd;
        logic        err;
        clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        dump_go = 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model[i] = '0;
        end
        tick(RST_CYCLES);
        rst = 1'b0;

        for (int i = 0; i < MEM_DEPTH; i++) begin
            take_bits(32, d);
            write_word("random fill", i, d);
        end
        read_image("random readback");

        // Misaligned and out of range in turn
        for (int t = 0; t < BAD_TRIES; t++) begin
            if (t % 2 == 0) begin
                take_bits(4, idx);
                take_bits(2, off);
                if (off == 0) begin
                    off = 1;
                end
                a = idx * MEM_ADDR_STEP + off;
            end else begin
                take_bits(32, a);
                a[31] = 1'b1;
                a[1:0] = 2'b00;
            end
            take_bits(32, d);
            apb_xfer(1'b1, a, d, rd, err);
            check_resp($sformatf("bad write %h", a), APB_ERR, err);
            apb_xfer(1'b0, a, '0, rd, err);
            check_resp($sformatf("bad read %h", a), APB_ERR, err);
        end
        read_image("image after bad access");

        run_dump("first dump", 1'b1);
        read_image("readback after dump");

        for (int i = 0; i < MEM_DEPTH; i++) begin
            take_bits(32, d);
            write_word("refill", i, d);
        end
        run_dump("second dump", 1'b0);

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== tests/mem_dump_chk.sv ====
module mem_dump_chk (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic dump_done,
    input logic sck,
    input logic ss,
    input logic mosi
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;

    // Zero wait states on every transfer
    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            $error("pready went low");
            fail_cnt++;
        end

    // sck only moves inside a frame
    a_sck_framed: assert property (@(posedge clk) disable iff (rst)
        (sck != $past(sck)) |-> !$past(ss))
        else begin
            $error("sck toggled while ss was high");
            fail_cnt++;
        end

    // Mode 0, data held while sck is high
    a_mosi_stable: assert property (@(posedge clk) disable iff (rst)
        (sck && $past(sck)) |-> $stable(mosi))
        else begin
            $error("mosi changed while sck was high");
            fail_cnt++;
        end

    a_done_idle: assert property (@(posedge clk) disable iff (rst) dump_done |-> ss)
        else begin
            $error("dump_done high while ss was low");
            fail_cnt++;
        end

endmodule

bind mem_dump_top mem_dump_chk i_chk (
    .clk       (clk),
    .rst       (rst),
    .pready    (pready),
    .dump_done (dump_done),
    .sck       (sck),
    .ss        (ss),
    .mosi      (mosi)
);

// ==== source/mem_dump_top.sv ====
module mem_dump_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  mem_pkg::mem_addr_t paddr,
    input  mem_pkg::mem_word_t pwdata,
    output mem_pkg::mem_word_t prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic               dump_go,
    output logic               dump_done,
    output logic               sck,
    output logic               ss,
    output logic               mosi
);

    logic spi_en;
    logic spi_busy;

    mem_tm_if tm_bus ();

    data_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tm_port (tm_bus.mem)
    );

    mem_send_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .dump_go   (dump_go),
        .dump_done (dump_done),
        .tm_port   (tm_bus.ctrl),
        .spi_en    (spi_en),
        .spi_busy  (spi_busy)
    );

    // Word goes straight from the test-mode read port
    spi_master_w u_spi (
        .clk  (clk),
        .rst  (rst),
        .word (tm_bus.rd),
        .en   (spi_en),
        .busy (spi_busy),
        .sck  (sck),
        .ss   (ss),
        .mosi (mosi)
    );

endmodule

// ==== source/spi_master_w.sv ====
module spi_master_w (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::mem_word_t word,
    input  logic               en,
    output logic               busy,
    output logic               sck,
    output logic               ss,
    output logic               mosi
);

    import mem_pkg::*;
    import spi_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_SHIFT,
        S_END
    } state_e;

    state_e    state;
    mem_word_t shreg;
    spi_cnt_t  bit_cnt;
    spi_half_t half_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            sck <= 1'b0;
            bit_cnt <= '0;
            half_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (en) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    state <= S_SHIFT;
                    sck <= 1'b0;
                    bit_cnt <= '0;
                    half_cnt <= '0;
                end
                S_SHIFT: begin
                    if (half_cnt == spi_half_t'(SPI_SCK_HALF - 1)) begin
                        half_cnt <= '0;
                        sck <= ~sck;
                        // Falling edge closes one bit
                        if (sck) begin
                            if (bit_cnt == spi_cnt_t'(SPI_WORD_BITS - 1)) begin
                                state <= S_END;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                S_END: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload, loaded on acceptance and shifted on falling sck
    always_ff @(posedge clk) begin
        if (state == S_IDLE && en) begin
            shreg <= word;
        end else if (state == S_SHIFT && sck
                     && half_cnt == spi_half_t'(SPI_SCK_HALF - 1)) begin
            shreg <= shreg << 1;
        end
    end

    assign busy = (state != S_IDLE);
    assign ss = (state != S_SHIFT);
    assign mosi = (state == S_SHIFT) ? shreg[SPI_WORD_BITS-1] : 1'b0;

endmodule

// ==== source/mem_send_ctrl.sv ====
module mem_send_ctrl (
    input  logic  clk,
    input  logic  rst,
    input  logic  dump_go,
    output logic  dump_done,
    mem_tm_if.ctrl tm_port,
    output logic  spi_en,
    input  logic  spi_busy
);

    import mem_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        SEND_WORD,
        WAIT_BUSY,
        WAIT_WORD,
        FINISHED
    } state_e;

    state_e    cs;
    mem_addr_t addr_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= IDLE;
            addr_reg <= '0;
        end else if (!dump_go) begin
            // Abort, the SPI master still completes its word
            cs <= IDLE;
            addr_reg <= '0;
        end else begin
            case (cs)
                IDLE: begin
                    if (!spi_busy) begin
                        cs <= SEND_WORD;
                    end
                end
                SEND_WORD: cs <= WAIT_BUSY;
                WAIT_BUSY: begin
                    if (spi_busy) begin
                        cs <= WAIT_WORD;
                    end
                end
                WAIT_WORD: begin
                    if (!spi_busy) begin
                        if (addr_reg == MEM_LAST_ADDR || tm_port.err) begin
                            cs <= FINISHED;
                            addr_reg <= '0;
                        end else begin
                            cs <= SEND_WORD;
                            addr_reg <= addr_reg + mem_addr_t'(MEM_ADDR_STEP);
                        end
                    end
                end
                FINISHED: cs <= FINISHED;
                default: cs <= IDLE;
            endcase
        end
    end

    assign tm_port.addr = addr_reg;
    assign tm_port.tm = (cs == SEND_WORD) || (cs == WAIT_BUSY) || (cs == WAIT_WORD);
    assign spi_en = (cs == SEND_WORD) || (cs == WAIT_BUSY);
    assign dump_done = (cs == FINISHED);

endmodule

// ==== source/data_mem.sv ====
module data_mem (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  mem_pkg::mem_addr_t  paddr,
    input  mem_pkg::mem_word_t  pwdata,
    output mem_pkg::mem_word_t  prdata,
    output logic                pready,
    output logic                pslverr,
    mem_tm_if.mem               tm_port
);

    import mem_pkg::*;

    mem_word_t mem [MEM_DEPTH];

    logic                    apb_access;
    logic                    apb_err;
    logic [MEM_IDX_BITS-1:0] apb_idx;
    logic [MEM_IDX_BITS-1:0] tm_idx;

    // Out of range or not word aligned
    function automatic logic addr_bad(input mem_addr_t a);
        return (a > MEM_LAST_ADDR) || (a[1:0] != 2'b00);
    endfunction

    assign apb_access = psel && penable;
    assign apb_idx = paddr[MEM_IDX_BITS+1:2];
    assign tm_idx = tm_port.addr[MEM_IDX_BITS+1:2];

    // Dump in progress locks the image against the host
    assign apb_err = addr_bad(paddr) || tm_port.tm;

    // Zero wait states
    assign pready = 1'b1;

    assign pslverr = (apb_access && apb_err) ? APB_ERR : APB_OK;
    assign prdata = apb_err ? '0 : mem[apb_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (apb_access && pwrite && !apb_err) begin
            mem[apb_idx] <= pwdata;
        end
    end

    // Test-mode read port
    assign tm_port.err = addr_bad(tm_port.addr);
    assign tm_port.rd = tm_port.err ? '0 : mem[tm_idx];

endmodule

// ==== source/mem_tm_if.sv ====
interface mem_tm_if;

    import mem_pkg::*;

    // Test mode owns the memory read port
    logic tm;
    mem_addr_t addr;

    // Answered combinationally by the memory
    mem_word_t rd;
    logic err;

    modport ctrl (
        output tm,
        output addr,
        input  rd,
        input  err
    );

    modport mem (
        input  tm,
        input  addr,
        output rd,
        output err
    );

endinterface

// ==== source/spi_pkg.sv ====
package spi_pkg;

    // clk cycles per half period of sck
    localparam int SPI_SCK_HALF = 2;

    // Bits per framed word
    localparam int SPI_WORD_BITS = 32;

    // Counters for bits and for clk cycles within a half period
    typedef logic [$clog2(SPI_WORD_BITS)-1:0] spi_cnt_t;
    typedef logic [$clog2(SPI_SCK_HALF + 1)-1:0] spi_half_t;

endpackage

// ==== source/mem_pkg.sv ====
package mem_pkg;

    // Data word and byte address of the dump memory
    typedef logic [31:0] mem_word_t;
    typedef logic [31:0] mem_addr_t;

    // Memory geometry
    localparam int MEM_DEPTH = 16;
    localparam int MEM_ADDR_STEP = 4;
    localparam int MEM_IDX_BITS = $clog2(MEM_DEPTH);

    // Byte address of the last word
    localparam mem_addr_t MEM_LAST_ADDR = mem_addr_t'((MEM_DEPTH - 1) * MEM_ADDR_STEP);

    // pslverr values
    localparam logic APB_OK = 1'b0;
    localparam logic APB_ERR = 1'b1;

endpackage
